/* Makefile */
# Verilator build and run of the branch predictor testbench
VERILATOR ?= verilator
TOP       ?= branch_predictor_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv tb/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/bp_pkg.sv */
`include "bp_settings.svh"

package bp_pkg;

    typedef logic [30:0] pc_t;                      // pc bits 31:1
    typedef logic [`BP_INDEX_BITS-1:0] tbl_idx_t;
    typedef logic [`BP_INDEX_BITS-1:0] ghist_t;
    typedef logic [1:0] ctr_t;                      // 2-bit saturating counter

    // correction code sent back to fetch
    typedef enum logic [1:0] {
        FIX_NOT_TAKEN = 2'd0,   // predicted taken, fell through
        FIX_TAKEN     = 2'd1,   // taken, missed or wrong target
        FIX_NONE      = 2'd2
    } fix_e;

    typedef enum logic {
        INIT_SWEEP = 1'b0,
        INIT_READY = 1'b1
    } init_state_e;

    typedef struct packed {
        pc_t  pc;
        logic predict;   // control transfer, look it up
        logic ctype;     // compressed
    } fetch_req_s;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } pred_s;

    typedef struct packed {
        logic     valid;
        logic     ctype;
        pc_t      pc;
        logic     pred_taken;
        pc_t      pred_target;
        tbl_idx_t pht_idx;   // counter index used at lookup
    } stage_s;

    typedef struct packed {
        logic taken;
        logic jtype;     // unconditional jump
        pc_t  target;
    } resolve_s;

    typedef struct packed {
        logic     btb_we;
        tbl_idx_t btb_idx;
        pc_t      btb_target;
        logic     pht_we;
        tbl_idx_t pht_idx;
        logic     pht_up;
        logic     hist_we;
    } train_s;

endpackage

/* rtl/bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// table geometry, index taken from pc bits [5:1]
`define BP_INDEX_BITS 5
`define BP_ENTRIES 32

// btb contents after init, in pc[31:1] form
`define BP_RESET_TARGET 31'h10

`endif

/* rtl/branch_predictor.sv */
`include "bp_settings.svh"

module branch_predictor (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               stall_i,
    input  bp_pkg::fetch_req_s fetch_i,
    input  bp_pkg::resolve_s   resolve_i,
    output logic               ready_o,
    output bp_pkg::pred_s      pred_o,
    output bp_pkg::fix_e       fix_o,
    output bp_pkg::pc_t        exec_pc_o,
    output logic               exec_ctype_o
);

    logic             sweep_we;
    bp_pkg::tbl_idx_t sweep_idx;
    bp_pkg::tbl_idx_t btb_rd_idx;
    bp_pkg::tbl_idx_t pht_rd_idx;
    bp_pkg::ghist_t   hist;
    bp_pkg::ctr_t     rd_ctr;
    bp_pkg::pc_t      rd_target;
    bp_pkg::train_s   train;

    assign btb_rd_idx = fetch_i.pc[`BP_INDEX_BITS-1:0];
    assign pht_rd_idx = btb_rd_idx ^ hist;   // gshare

    // counter msb says taken, only for real transfers once tables are loaded
    assign pred_o = '{taken: rd_ctr[1] && fetch_i.predict && ready_o, target: rd_target};

    table_init_ctrl table_init_ctrl_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sweep_we_o  (sweep_we),
        .sweep_idx_o (sweep_idx),
        .ready_o     (ready_o)
    );

    pht_counter_table pht_counter_table_inst (
        .clk_i      (clk_i),
        .rd_idx_i   (pht_rd_idx),
        .rd_ctr_o   (rd_ctr),
        .train_i    (train),
        .init_we_i  (sweep_we),
        .init_idx_i (sweep_idx)
    );

    btb_table btb_table_inst (
        .clk_i       (clk_i),
        .rd_idx_i    (btb_rd_idx),
        .rd_target_o (rd_target),
        .train_i     (train),
        .init_we_i   (sweep_we),
        .init_idx_i  (sweep_idx)
    );

    global_history global_history_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .clear_i (sweep_we),   // history starts empty with the tables
        .stall_i (stall_i),
        .shift_i (train.hist_we),
        .taken_i (resolve_i.taken),
        .hist_o  (hist)
    );

    resolve_stage resolve_stage_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .ready_i      (ready_o),
        .fetch_i      (fetch_i),
        .pred_i       (pred_o),
        .pht_idx_i    (pht_rd_idx),
        .resolve_i    (resolve_i),
        .train_o      (train),
        .fix_o        (fix_o),
        .exec_pc_o    (exec_pc_o),
        .exec_ctype_o (exec_ctype_o)
    );

endmodule

/* rtl/btb_table.sv */
`include "bp_settings.svh"

module btb_table (
    input  logic             clk_i,
    input  bp_pkg::tbl_idx_t rd_idx_i,
    output bp_pkg::pc_t      rd_target_o,
    input  bp_pkg::train_s   train_i,
    input  logic             init_we_i,
    input  bp_pkg::tbl_idx_t init_idx_i
);

    bp_pkg::pc_t mem [`BP_ENTRIES];

    // no tag, any pc aliasing to the entry gets its target
    assign rd_target_o = mem[rd_idx_i];

    always_ff @(posedge clk_i) begin
        if (init_we_i) begin
            mem[init_idx_i] <= `BP_RESET_TARGET;
        end else if (train_i.btb_we) begin
            mem[train_i.btb_idx] <= train_i.btb_target;   // learned target
        end
    end

endmodule

/* rtl/global_history.sv */
`include "bp_settings.svh"

module global_history (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           clear_i,
    input  logic           stall_i,
    input  logic           shift_i,
    input  logic           taken_i,
    output bp_pkg::ghist_t hist_o
);

    bp_pkg::ghist_t hist_q;

    // newest outcome sits in bit 0
    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            hist_q <= '0;
        end else if (shift_i && !stall_i) begin
            hist_q <= {hist_q[`BP_INDEX_BITS-2:0], taken_i};
        end
    end

    assign hist_o = hist_q;

endmodule

/* rtl/pht_counter_table.sv */
`include "bp_settings.svh"

module pht_counter_table (
    input  logic             clk_i,
    input  bp_pkg::tbl_idx_t rd_idx_i,
    output bp_pkg::ctr_t     rd_ctr_o,
    input  bp_pkg::train_s   train_i,
    input  logic             init_we_i,
    input  bp_pkg::tbl_idx_t init_idx_i
);

    bp_pkg::ctr_t mem [`BP_ENTRIES];

    bp_pkg::ctr_t train_cur;
    bp_pkg::ctr_t train_next;

    assign rd_ctr_o  = mem[rd_idx_i];
    assign train_cur = mem[train_i.pht_idx];

    // saturating step toward the resolved direction
    always_comb begin
        train_next = train_cur;
        if (train_i.pht_up) begin
            if (train_cur != 2'b11) begin
                train_next = train_cur + 2'd1;
            end
        end else if (train_cur != 2'b00) begin
            train_next = train_cur - 2'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (init_we_i) begin
            mem[init_idx_i] <= 2'b11;   // strongly taken
        end else if (train_i.pht_we) begin
            mem[train_i.pht_idx] <= train_next;
        end
    end

    // strongly taken stays there on another taken outcome
    sat_high_a: assert property (@(posedge clk_i)
        train_i.pht_we && !init_we_i && train_i.pht_up && train_cur == 2'b11
        |=> mem[$past(train_i.pht_idx)] == 2'b11);

    // strongly not taken stays there on another not-taken outcome
    sat_low_a: assert property (@(posedge clk_i)
        train_i.pht_we && !init_we_i && !train_i.pht_up && train_cur == 2'b00
        |=> mem[$past(train_i.pht_idx)] == 2'b00);

endmodule

/* rtl/resolve_stage.sv */
`include "bp_settings.svh"

module resolve_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               stall_i,
    input  logic               ready_i,
    input  bp_pkg::fetch_req_s fetch_i,
    input  bp_pkg::pred_s      pred_i,
    input  bp_pkg::tbl_idx_t   pht_idx_i,
    input  bp_pkg::resolve_s   resolve_i,
    output bp_pkg::train_s     train_o,
    output bp_pkg::fix_e       fix_o,
    output bp_pkg::pc_t        exec_pc_o,
    output logic               exec_ctype_o
);

    bp_pkg::stage_s dec_d;
    bp_pkg::stage_s dec_q;
    bp_pkg::stage_s exe_q;

    logic target_ok;
    logic taken_miss;
    logic not_taken_miss;
    logic write_ok;
    logic cond_br;

    // capture of the lookup made this cycle
    always_comb begin
        dec_d.valid       = fetch_i.predict && ready_i;   // nothing tracked during init
        dec_d.ctype       = fetch_i.ctype;
        dec_d.pc          = fetch_i.pc;
        dec_d.pred_taken  = pred_i.taken;
        dec_d.pred_target = pred_i.target;
        dec_d.pht_idx     = pht_idx_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_q.valid <= 1'b0;
            exe_q.valid <= 1'b0;
        end else if (!stall_i) begin
            dec_q <= dec_d;
            exe_q <= dec_q;
        end
    end

    assign target_ok      = (exe_q.pred_target == resolve_i.target);
    assign taken_miss     = resolve_i.taken && (!exe_q.pred_taken || !target_ok);
    assign not_taken_miss = !resolve_i.taken && exe_q.pred_taken;

    always_comb begin
        fix_o = bp_pkg::FIX_NONE;
        if (exe_q.valid) begin
            if (taken_miss) begin
                fix_o = bp_pkg::FIX_TAKEN;
            end else if (not_taken_miss) begin
                fix_o = bp_pkg::FIX_NOT_TAKEN;
            end
        end
    end

    // tables and history move only on a stall-free edge
    assign write_ok = exe_q.valid && !stall_i;
    assign cond_br  = !resolve_i.jtype;

    always_comb begin
        train_o.btb_we     = write_ok && taken_miss;
        train_o.btb_idx    = exe_q.pc[`BP_INDEX_BITS-1:0];   // pc bits [5:1]
        train_o.btb_target = resolve_i.target;
        train_o.pht_we     = write_ok && cond_br;
        train_o.pht_idx    = exe_q.pht_idx;                  // same entry that predicted
        train_o.pht_up     = resolve_i.taken;
        train_o.hist_we    = write_ok && cond_br;
    end

    assign exec_pc_o    = exe_q.pc;
    assign exec_ctype_o = exe_q.ctype;

    // an empty decode slot, or a reset, leaves nothing to correct next cycle
    no_fix_when_empty_a: assert property (@(posedge clk_i)
        $past(rst_i) || $past(!stall_i && !dec_q.valid)
        |-> fix_o == bp_pkg::FIX_NONE);

endmodule

/* rtl/table_init_ctrl.sv */
`include "bp_settings.svh"

module table_init_ctrl (
    input  logic             clk_i,
    input  logic             rst_i,
    output logic             sweep_we_o,
    output bp_pkg::tbl_idx_t sweep_idx_o,
    output logic             ready_o
);

    localparam bp_pkg::tbl_idx_t LAST_IDX = bp_pkg::tbl_idx_t'(`BP_ENTRIES - 1);

    bp_pkg::init_state_e state_q, state_d;
    bp_pkg::tbl_idx_t    idx_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            bp_pkg::INIT_SWEEP: begin
                if (idx_q == LAST_IDX) begin
                    state_d = bp_pkg::INIT_READY;   // last entry written this cycle
                end
            end
            default: state_d = bp_pkg::INIT_READY;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= bp_pkg::INIT_SWEEP;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == bp_pkg::INIT_SWEEP) begin
                idx_q <= idx_q + 1'b1;   // one entry per cycle
            end
        end
    end

    assign sweep_we_o  = (state_q == bp_pkg::INIT_SWEEP);
    assign sweep_idx_o = idx_q;
    assign ready_o     = (state_q == bp_pkg::INIT_READY);

    // once up, only a reset takes the predictor back to the sweep
    ready_hold_a: assert property (@(posedge clk_i)
        $fell(ready_o) |-> $past(rst_i));

endmodule

/* tb/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// expected predictor state, advanced once per rising edge
bp_pkg::ctr_t   ref_pht [`BP_ENTRIES];
bp_pkg::pc_t    ref_btb [`BP_ENTRIES];
bp_pkg::ghist_t ref_hist;
bp_pkg::stage_s ref_dec;
bp_pkg::stage_s ref_exe;
int unsigned    ref_init_cnt;   // edges since reset release
logic [15:0]    lfsr_q = 16'd58434;

function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one lfsr step per returned bit
function automatic logic [7:0] take_bits(int n);
    logic [7:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v = {v[6:0], lfsr_q[0]};
    end
    return v;
endfunction

function automatic logic ref_ready();
    return ref_init_cnt >= `BP_ENTRIES;
endfunction

function automatic bp_pkg::tbl_idx_t ref_pht_idx(bp_pkg::pc_t pc);
    return pc[`BP_INDEX_BITS-1:0] ^ ref_hist;   // gshare index
endfunction

function automatic bp_pkg::pred_s ref_pred(bp_pkg::fetch_req_s req);
    bp_pkg::pred_s p;
    p.taken  = ref_pht[ref_pht_idx(req.pc)][1] && req.predict && ref_ready();
    p.target = ref_btb[req.pc[`BP_INDEX_BITS-1:0]];
    return p;
endfunction

function automatic bp_pkg::fix_e ref_fix(bp_pkg::resolve_s res);
    if (!ref_exe.valid) begin
        return bp_pkg::FIX_NONE;
    end
    if (res.taken && (!ref_exe.pred_taken || ref_exe.pred_target != res.target)) begin
        return bp_pkg::FIX_TAKEN;
    end
    if (!res.taken && ref_exe.pred_taken) begin
        return bp_pkg::FIX_NOT_TAKEN;
    end
    return bp_pkg::FIX_NONE;
endfunction

function automatic bp_pkg::ctr_t ref_ctr_next(bp_pkg::ctr_t c, logic up);
    if (up) begin
        return (c == 2'b11) ? c : c + 2'd1;
    end
    return (c == 2'b00) ? c : c - 2'd1;
endfunction

task automatic ref_reset();
    for (int k = 0; k < `BP_ENTRIES; k++) begin
        ref_pht[k] = 2'b11;
        ref_btb[k] = `BP_RESET_TARGET;
    end
    ref_hist     = '0;
    ref_dec      = '0;
    ref_exe      = '0;
    ref_init_cnt = 0;
endtask

// effect of one rising edge with the given inputs
task automatic ref_step(input logic rst, input logic stall,
                        input bp_pkg::fetch_req_s req, input bp_pkg::resolve_s res);
    bp_pkg::pred_s  p;
    bp_pkg::stage_s nxt;
    if (rst) begin
        ref_reset();
        return;
    end
    p               = ref_pred(req);
    nxt.valid       = req.predict && ref_ready();
    nxt.ctype       = req.ctype;
    nxt.pc          = req.pc;
    nxt.pred_taken  = p.taken;
    nxt.pred_target = p.target;
    nxt.pht_idx     = ref_pht_idx(req.pc);
    if (ref_init_cnt < `BP_ENTRIES) begin
        ref_init_cnt++;   // sweep runs through stalls
    end
    if (!stall) begin
        if (ref_exe.valid) begin
            if (ref_fix(res) == bp_pkg::FIX_TAKEN) begin
                ref_btb[ref_exe.pc[`BP_INDEX_BITS-1:0]] = res.target;
            end
            if (!res.jtype) begin
                ref_pht[ref_exe.pht_idx] = ref_ctr_next(ref_pht[ref_exe.pht_idx], res.taken);
                ref_hist = {ref_hist[`BP_INDEX_BITS-2:0], res.taken};
            end
        end
        ref_exe = ref_dec;
        ref_dec = nxt;
    end
endtask

`endif

/* tb/branch_predictor_tb.sv */
`include "bp_settings.svh"

module branch_predictor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 20;
    localparam int RANDOM_CYCLES   = 600;
    localparam int DRAIN_CYCLES    = 4;
    localparam int SEQ_CYCLES      = RESET_CYCLES + `BP_ENTRIES + DIRECTED_CYCLES
                                     + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam int MARGIN_CYCLES   = 100;

    localparam bp_pkg::pc_t PC_A  = 31'h0000_0105;   // index 5
    localparam bp_pkg::pc_t PC_B  = 31'h0000_0049;   // index 9
    localparam bp_pkg::pc_t PC_C  = 31'h0000_022c;   // index 12
    localparam bp_pkg::pc_t TGT_B = 31'h0000_02a4;
    localparam bp_pkg::pc_t TGT_C = 31'h0000_0300;

    // pc 0x45 aliases with PC_A in the btb
    localparam bp_pkg::pc_t PC_POOL [8] = '{31'h105, 31'h49, 31'h22c, 31'h45,
                                            31'h7f3, 31'h1a0, 31'h316, 31'h08e};
    localparam bp_pkg::pc_t TGT_POOL [4] = '{`BP_RESET_TARGET, 31'h2a4, 31'h300, 31'h5c8};

    logic               clk_i;
    logic               rst_i;
    logic               stall_i;
    bp_pkg::fetch_req_s fetch_i;
    bp_pkg::resolve_s   resolve_i;
    logic               ready_o;
    bp_pkg::pred_s      pred_o;
    bp_pkg::fix_e       fix_o;
    bp_pkg::pc_t        exec_pc_o;
    logic               exec_ctype_o;

    string test_name = "reset";

    `include "bp_ref_model.svh"

    branch_predictor branch_predictor_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .fetch_i      (fetch_i),
        .resolve_i    (resolve_i),
        .ready_o      (ready_o),
        .pred_o       (pred_o),
        .fix_o        (fix_o),
        .exec_pc_o    (exec_pc_o),
        .exec_ctype_o (exec_ctype_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "test aborted");
    endtask

    // caller sits at a falling edge
    task automatic drive(input logic stall, input logic predict, input bp_pkg::pc_t pc,
                         input logic taken, input logic jtype, input bp_pkg::pc_t target);
        stall_i   = stall;
        fetch_i   = '{pc: pc, predict: predict, ctype: pc[2]};
        resolve_i = '{taken: taken, jtype: jtype, target: target};
    endtask

    task automatic cycle(input logic stall, input logic predict, input bp_pkg::pc_t pc,
                         input logic taken, input logic jtype, input bp_pkg::pc_t target);
        drive(stall, predict, pc, taken, jtype, target);
        @(negedge clk_i);
    endtask

    task automatic idle();
        cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic expect_pred(input logic taken, input bp_pkg::pc_t target);
        bp_pkg::pred_s exp;
        exp = '{taken: taken, target: target};
        #(CLK_PERIOD / 8);
        assert (pred_o == exp) else report_mismatch("pred_o", 64'(exp), 64'(pred_o));
        @(negedge clk_i);
    endtask

    task automatic expect_fix(input bp_pkg::fix_e exp);
        #(CLK_PERIOD / 8);
        assert (fix_o == exp) else report_mismatch("fix_o", 64'(exp), 64'(fix_o));
        @(negedge clk_i);
    endtask

    // fetch, one cycle in decode, resolve in execute
    task automatic branch(input string name, input bp_pkg::pc_t pc, input logic jtype,
                          input logic taken, input bp_pkg::pc_t target,
                          input logic exp_taken, input bp_pkg::pc_t exp_target,
                          input bp_pkg::fix_e exp_fix);
        test_name = name;
        drive(1'b0, 1'b1, pc, 1'b0, 1'b0, '0);
        expect_pred(exp_taken, exp_target);
        idle();
        drive(1'b0, 1'b0, '0, taken, jtype, target);
        expect_fix(exp_fix);
    endtask

    initial begin : stimulus
        logic [7:0]  r;
        logic        stall;
        logic        predict;
        logic        taken;
        logic        jtype;
        bp_pkg::pc_t pc;
        bp_pkg::pc_t target;
        rst_i     = 1'b1;
        stall_i   = 1'b0;
        fetch_i   = '0;
        resolve_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i     = 1'b0;
        test_name = "init";
        while (!ready_o) begin
            r = take_bits(3);
            cycle(1'b0, take_bits(1) != 8'd0, PC_POOL[r[2:0]], 1'b0, 1'b0, '0);
        end

        branch("first lookup", PC_A, 1'b0, 1'b0, '0, 1'b1, `BP_RESET_TARGET,
               bp_pkg::FIX_NOT_TAKEN);
        branch("new target", PC_B, 1'b0, 1'b1, TGT_B, 1'b1, `BP_RESET_TARGET,
               bp_pkg::FIX_TAKEN);
        branch("learned target", PC_B, 1'b0, 1'b1, TGT_B, 1'b1, TGT_B, bp_pkg::FIX_NONE);
        branch("jump", PC_C, 1'b1, 1'b1, TGT_C, 1'b1, `BP_RESET_TARGET, bp_pkg::FIX_TAKEN);
        branch("jump repeat", PC_C, 1'b1, 1'b1, TGT_C, 1'b1, TGT_C, bp_pkg::FIX_NONE);

        test_name = "random";
        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            stall   = take_bits(3) == 8'd0;
            predict = take_bits(2) != 8'd0;
            r       = take_bits(3);
            pc      = PC_POOL[r[2:0]];
            // mostly not taken first, mostly taken later, so counters hit both ends
            if (k < RANDOM_CYCLES / 2) begin
                taken = take_bits(2) == 8'd0;
            end else begin
                taken = take_bits(2) != 8'd0;
            end
            jtype   = take_bits(3) == 8'd0;
            r       = take_bits(2);
            target  = TGT_POOL[r[1:0]];
            cycle(stall, predict, pc, taken, jtype, target);
        end
        test_name = "drain";
        repeat (DRAIN_CYCLES) idle();
        $display("STATUS: PASS");
        $finish;
    end

    // compares between the falling and rising edge, then steps the model
    initial begin : compare
        bp_pkg::pred_s exp_pred;
        bp_pkg::fix_e  exp_fix;
        ref_reset();
        forever begin
            @(negedge clk_i);
            #(CLK_PERIOD / 4);
            assert (ready_o == ref_ready())
                else report_mismatch("ready_o", 64'(ref_ready()), 64'(ready_o));
            exp_fix = ref_fix(resolve_i);
            assert (fix_o == exp_fix) else report_mismatch("fix_o", 64'(exp_fix), 64'(fix_o));
            if (ref_ready()) begin
                exp_pred = ref_pred(fetch_i);
                assert (pred_o == exp_pred)
                    else report_mismatch("pred_o", 64'(exp_pred), 64'(pred_o));
            end else begin
                assert (!pred_o.taken) else report_error("taken prediction before ready");
                assert (!branch_predictor_inst.resolve_stage_inst.dec_q.valid &&
                        !branch_predictor_inst.resolve_stage_inst.exe_q.valid)
                    else report_error("tracking stage valid before ready");
            end
            if (ref_exe.valid) begin
                assert (exec_pc_o == ref_exe.pc)
                    else report_mismatch("exec_pc_o", 64'(ref_exe.pc), 64'(exec_pc_o));
                assert (exec_ctype_o == ref_exe.ctype)
                    else report_mismatch("exec_ctype_o", 64'(ref_exe.ctype), 64'(exec_ctype_o));
            end
            ref_step(rst_i, stall_i, fetch_i, resolve_i);
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (SEQ_CYCLES + MARGIN_CYCLES));
        report_error("watchdog expired before the test sequence finished");
    end

endmodule

/* vlog.f */
+incdir+rtl
+incdir+tb
rtl/bp_pkg.sv
rtl/table_init_ctrl.sv
rtl/pht_counter_table.sv
rtl/btb_table.sv
rtl/global_history.sv
rtl/resolve_stage.sv
rtl/branch_predictor.sv
tb/branch_predictor_tb.sv
